// File: common/soc_pkg.sv
package soc_pkg;

  // bus widths
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned SEL_W      = DATA_W / 8;
  localparam int unsigned DBG_DATA_W = 32;
  localparam int unsigned DBG_SEL_W  = DBG_DATA_W / 8;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [SEL_W-1:0]      sel_t;
  typedef logic [DBG_DATA_W-1:0] dbg_data_t;
  typedef logic [DBG_SEL_W-1:0]  dbg_sel_t;

  // address map
  localparam addr_t       L2_BASE  = 32'h1C00_0000;
  localparam addr_t       DBG_BASE = 32'h1A11_0000;
  localparam int unsigned DBG_SIZE = 4096;

  typedef enum logic [1:0] {
    REGION_L2,
    REGION_DBG,
    REGION_EXT
  } region_e;

  // region lookup, everything unmapped goes out through the ext port
  function automatic region_e addr_region(input addr_t addr, input int unsigned l2_size);
    region_e region;
    region = REGION_EXT;
    // offsets against the base avoid overflow of base + size
    if ((addr >= L2_BASE) && ((addr - L2_BASE) < addr_t'(l2_size))) begin
      region = REGION_L2;
    end else if ((addr >= DBG_BASE) && ((addr - DBG_BASE) < addr_t'(DBG_SIZE))) begin
      region = REGION_DBG;
    end
    return region;
  endfunction

endpackage

// File: soc_bus/soc_bus.sv
module soc_bus #(
  parameter int unsigned L2_N_PORTS = 2,
  parameter int unsigned L2_SIZE    = 65536
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // host slave port
  input  logic                  host_cyc_i,
  input  logic                  host_stb_i,
  input  logic                  host_we_i,
  input  soc_pkg::addr_t        host_adr_i,
  input  soc_pkg::data_t        host_dat_i,
  input  soc_pkg::sel_t         host_sel_i,
  output logic                  host_ack_o,
  output soc_pkg::data_t        host_dat_o,

  // l2 banks
  output logic [L2_N_PORTS-1:0] l2_cyc_o,
  output logic [L2_N_PORTS-1:0] l2_stb_o,
  output logic [L2_N_PORTS-1:0] l2_we_o,
  output soc_pkg::addr_t        l2_adr_o [L2_N_PORTS],
  output soc_pkg::data_t        l2_dat_o [L2_N_PORTS],
  output soc_pkg::sel_t         l2_sel_o [L2_N_PORTS],
  input  logic [L2_N_PORTS-1:0] l2_ack_i,
  input  soc_pkg::data_t        l2_dat_i [L2_N_PORTS],

  // debug path still 64 bit wide here
  output logic                  dws_cyc_o,
  output logic                  dws_stb_o,
  output logic                  dws_we_o,
  output soc_pkg::addr_t        dws_adr_o,
  output soc_pkg::data_t        dws_dat_o,
  output soc_pkg::sel_t         dws_sel_o,
  input  logic                  dws_ack_i,
  input  soc_pkg::data_t        dws_dat_i,

  // external master port
  output logic                  ext_cyc_o,
  output logic                  ext_stb_o,
  output logic                  ext_we_o,
  output soc_pkg::addr_t        ext_adr_o,
  output soc_pkg::data_t        ext_dat_o,
  output soc_pkg::sel_t         ext_sel_o,
  input  logic                  ext_ack_i,
  input  soc_pkg::data_t        ext_dat_i
);

  import soc_pkg::*;

  // bank bits sit right above the 8-byte word offset
  localparam int unsigned BYTE_SHIFT = $clog2(SEL_W);
  localparam int unsigned BANK_SHIFT = BYTE_SHIFT + $clog2(L2_N_PORTS);

  region_e region_d;
  region_e region_q;
  region_e region;
  logic    busy_q;
  logic    host_req;
  logic    target_ack;
  addr_t   l2_off;
  addr_t   l2_bank;

  assign host_req = host_cyc_i & host_stb_i;
  assign region_d = addr_region(host_adr_i, L2_SIZE);
  // steering frozen once a request is open
  assign region   = busy_q ? region_q : region_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      region_q <= REGION_EXT;
    end else begin
      busy_q <= host_req & ~host_ack_o;
      if (!busy_q) begin
        region_q <= region_d;
      end
    end
  end

  assign l2_off  = host_adr_i - L2_BASE;
  assign l2_bank = (l2_off >> BYTE_SHIFT) & addr_t'(L2_N_PORTS - 1);

  always_comb begin
    for (int i = 0; i < L2_N_PORTS; i++) begin
      l2_cyc_o[i] = host_cyc_i && (region == REGION_L2) && (l2_bank == addr_t'(i));
      l2_stb_o[i] = host_stb_i && (region == REGION_L2) && (l2_bank == addr_t'(i));
      l2_we_o[i]  = host_we_i;
      // word index inside the bank
      l2_adr_o[i] = l2_off >> BANK_SHIFT;
      l2_dat_o[i] = host_dat_i;
      l2_sel_o[i] = host_sel_i;
    end
  end

  assign dws_cyc_o = host_cyc_i && (region == REGION_DBG);
  assign dws_stb_o = host_stb_i && (region == REGION_DBG);
  assign dws_we_o  = host_we_i;
  assign dws_adr_o = host_adr_i;
  assign dws_dat_o = host_dat_i;
  assign dws_sel_o = host_sel_i;

  assign ext_cyc_o = host_cyc_i && (region == REGION_EXT);
  assign ext_stb_o = host_stb_i && (region == REGION_EXT);
  assign ext_we_o  = host_we_i;
  assign ext_adr_o = host_adr_i;
  assign ext_dat_o = host_dat_i;
  assign ext_sel_o = host_sel_i;

  // response mux
  always_comb begin
    target_ack = 1'b0;
    host_dat_o = '0;
    case (region)
      REGION_L2: begin
        for (int i = 0; i < L2_N_PORTS; i++) begin
          if (l2_bank == addr_t'(i)) begin
            target_ack = l2_ack_i[i];
            host_dat_o = l2_dat_i[i];
          end
        end
      end
      REGION_DBG: begin
        target_ack = dws_ack_i;
        host_dat_o = dws_dat_i;
      end
      default: begin
        target_ack = ext_ack_i;
        host_dat_o = ext_dat_i;
      end
    endcase
  end

  assign host_ack_o = target_ack;

endmodule

// File: l2_mem/l2_mem.sv
module l2_mem #(
  parameter int unsigned N_BYTES = 32768
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  input  soc_pkg::sel_t  sel_i,
  output logic           ack_o,
  output soc_pkg::data_t dat_o
);

  import soc_pkg::*;

  localparam int unsigned N_WORDS = N_BYTES / SEL_W;
  localparam int unsigned IDX_W   = $clog2(N_WORDS);

  data_t            mem_q [N_WORDS];
  data_t            dat_q;
  logic [IDX_W-1:0] idx;
  logic             req;
  logic             ack_q;

  // adr_i already holds the word index within this bank
  assign idx = adr_i[IDX_W-1:0];
  // new access only while no ack is pending
  assign req = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we_i) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel_i[b]) begin
            mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
      // full word, select bits only matter for writes
      dat_q <= mem_q[idx];
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

endmodule

// File: verilog/dw_downsizer.sv
module dw_downsizer (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // wide slave side
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     adr_i,
  input  soc_pkg::data_t     dat_i,
  input  soc_pkg::sel_t      sel_i,
  output logic               ack_o,
  output soc_pkg::data_t     dat_o,

  // narrow master side
  output logic               n_cyc_o,
  output logic               n_stb_o,
  output logic               n_we_o,
  output soc_pkg::addr_t     n_adr_o,
  output soc_pkg::dbg_data_t n_dat_o,
  output soc_pkg::dbg_sel_t  n_sel_o,
  input  logic               n_ack_i,
  input  soc_pkg::dbg_data_t n_dat_i
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    DWS_IDLE,
    DWS_LOW,
    DWS_HIGH,
    DWS_DONE
  } dws_state_e;

  dws_state_e state_q;
  dws_state_e state_d;
  logic       need_hi_q;
  logic       need_hi_d;
  logic       touch_lo;
  logic       touch_hi;
  logic       hi_phase;
  data_t      rdata_q;

  assign touch_lo = |sel_i[DBG_SEL_W-1:0];
  assign touch_hi = |sel_i[SEL_W-1:DBG_SEL_W];
  assign hi_phase = (state_q == DWS_HIGH);

  always_comb begin
    state_d   = state_q;
    need_hi_d = need_hi_q;
    case (state_q)
      DWS_IDLE: begin
        if (cyc_i && stb_i) begin
          need_hi_d = touch_lo & touch_hi;
          // empty select still makes one access, to the low half
          state_d   = (touch_hi && !touch_lo) ? DWS_HIGH : DWS_LOW;
        end
      end
      DWS_LOW: begin
        if (n_ack_i) begin
          state_d = need_hi_q ? DWS_HIGH : DWS_DONE;
        end
      end
      DWS_HIGH: begin
        if (n_ack_i) begin
          state_d = DWS_DONE;
        end
      end
      default: begin
        state_d = DWS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= DWS_IDLE;
      need_hi_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      need_hi_q <= need_hi_d;
    end
  end

  // gather read halves, untouched half stays zero
  always_ff @(posedge clk_i) begin
    if (state_q == DWS_IDLE) begin
      rdata_q <= '0;
    end else if (n_stb_o && n_ack_i && !we_i) begin
      if (hi_phase) begin
        rdata_q[DATA_W-1:DBG_DATA_W] <= n_dat_i;
      end else begin
        rdata_q[DBG_DATA_W-1:0] <= n_dat_i;
      end
    end
  end

  assign n_cyc_o = (state_q == DWS_LOW) || hi_phase;
  assign n_stb_o = n_cyc_o;
  assign n_we_o  = we_i;
  // bit 2 picks the 32-bit half
  assign n_adr_o = {adr_i[ADDR_W-1:3], hi_phase, 2'b00};
  assign n_dat_o = hi_phase ? dat_i[DATA_W-1:DBG_DATA_W] : dat_i[DBG_DATA_W-1:0];
  assign n_sel_o = hi_phase ? sel_i[SEL_W-1:DBG_SEL_W] : sel_i[DBG_SEL_W-1:0];

  assign ack_o = (state_q == DWS_DONE);
  assign dat_o = rdata_q;

endmodule

// File: verilog/dbg_scratch_ram.sv
module dbg_scratch_ram (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_pkg::addr_t     adr_i,
  input  soc_pkg::dbg_data_t dat_i,
  input  soc_pkg::dbg_sel_t  sel_i,
  output logic               ack_o,
  output soc_pkg::dbg_data_t dat_o
);

  import soc_pkg::*;

  // 1024 words over the whole debug region
  localparam int unsigned N_WORDS  = DBG_SIZE / DBG_SEL_W;
  localparam int unsigned IDX_W    = $clog2(N_WORDS);
  localparam int unsigned BYTE_OFF = $clog2(DBG_SEL_W);

  dbg_data_t        mem_q [N_WORDS];
  dbg_data_t        dat_q;
  logic [IDX_W-1:0] idx;
  logic             req;
  logic             ack_q;

  assign idx = adr_i[IDX_W+BYTE_OFF-1:BYTE_OFF];
  assign req = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we_i) begin
        for (int b = 0; b < DBG_SEL_W; b++) begin
          if (sel_i[b]) begin
            mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
      dat_q <= mem_q[idx];
    end
  end

  assign ack_o = ack_q;
  assign dat_o = dat_q;

endmodule

// File: verilog/pulp_soc.sv
module pulp_soc #(
  parameter int unsigned L2_N_PORTS = 2,      // power of 2
  parameter int unsigned L2_SIZE    = 65536   // bytes
) (
  input  logic           clk_i,
  input  logic           rst_n_i,

  // host master
  input  logic           host_cyc_i,
  input  logic           host_stb_i,
  input  logic           host_we_i,
  input  soc_pkg::addr_t host_adr_i,
  input  soc_pkg::data_t host_dat_i,
  input  soc_pkg::sel_t  host_sel_i,
  output logic           host_ack_o,
  output soc_pkg::data_t host_dat_o,

  // everything outside l2 and debug
  output logic           ext_cyc_o,
  output logic           ext_stb_o,
  output logic           ext_we_o,
  output soc_pkg::addr_t ext_adr_o,
  output soc_pkg::data_t ext_dat_o,
  output soc_pkg::sel_t  ext_sel_o,
  input  logic           ext_ack_i,
  input  soc_pkg::data_t ext_dat_i
);

  import soc_pkg::*;

  // bus to l2 banks
  logic [L2_N_PORTS-1:0] l2_cyc;
  logic [L2_N_PORTS-1:0] l2_stb;
  logic [L2_N_PORTS-1:0] l2_we;
  addr_t                 l2_adr [L2_N_PORTS];
  data_t                 l2_dat_w [L2_N_PORTS];
  sel_t                  l2_sel [L2_N_PORTS];
  logic [L2_N_PORTS-1:0] l2_ack;
  data_t                 l2_dat_r [L2_N_PORTS];

  // bus to downsizer
  logic      dws_cyc, dws_stb, dws_we, dws_ack;
  addr_t     dws_adr;
  data_t     dws_dat_w, dws_dat_r;
  sel_t      dws_sel;

  // downsizer to scratch ram
  logic      dram_cyc, dram_stb, dram_we, dram_ack;
  addr_t     dram_adr;
  dbg_data_t dram_dat_w, dram_dat_r;
  dbg_sel_t  dram_sel;

  soc_bus #(
    .L2_N_PORTS (L2_N_PORTS),
    .L2_SIZE    (L2_SIZE)
  ) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .host_cyc_i, .host_stb_i, .host_we_i,
    .host_adr_i, .host_dat_i, .host_sel_i,
    .host_ack_o, .host_dat_o,
    .l2_cyc_o (l2_cyc),  .l2_stb_o (l2_stb),   .l2_we_o  (l2_we),
    .l2_adr_o (l2_adr),  .l2_dat_o (l2_dat_w), .l2_sel_o (l2_sel),
    .l2_ack_i (l2_ack),  .l2_dat_i (l2_dat_r),
    .dws_cyc_o (dws_cyc), .dws_stb_o (dws_stb),   .dws_we_o  (dws_we),
    .dws_adr_o (dws_adr), .dws_dat_o (dws_dat_w), .dws_sel_o (dws_sel),
    .dws_ack_i (dws_ack), .dws_dat_i (dws_dat_r),
    .ext_cyc_o, .ext_stb_o, .ext_we_o,
    .ext_adr_o, .ext_dat_o, .ext_sel_o,
    .ext_ack_i, .ext_dat_i
  );

  for (genvar i = 0; i < L2_N_PORTS; i++) begin : gen_l2_banks
    l2_mem #(
      .N_BYTES (L2_SIZE / L2_N_PORTS)
    ) i_l2_mem (
      .clk_i, .rst_n_i,
      .cyc_i (l2_cyc[i]), .stb_i (l2_stb[i]),   .we_i  (l2_we[i]),
      .adr_i (l2_adr[i]), .dat_i (l2_dat_w[i]), .sel_i (l2_sel[i]),
      .ack_o (l2_ack[i]), .dat_o (l2_dat_r[i])
    );
  end

  dw_downsizer i_dw_downsizer (
    .clk_i, .rst_n_i,
    .cyc_i (dws_cyc), .stb_i (dws_stb),   .we_i  (dws_we),
    .adr_i (dws_adr), .dat_i (dws_dat_w), .sel_i (dws_sel),
    .ack_o (dws_ack), .dat_o (dws_dat_r),
    .n_cyc_o (dram_cyc), .n_stb_o (dram_stb),   .n_we_o  (dram_we),
    .n_adr_o (dram_adr), .n_dat_o (dram_dat_w), .n_sel_o (dram_sel),
    .n_ack_i (dram_ack), .n_dat_i (dram_dat_r)
  );

  dbg_scratch_ram i_dbg_scratch_ram (
    .clk_i, .rst_n_i,
    .cyc_i (dram_cyc), .stb_i (dram_stb),   .we_i  (dram_we),
    .adr_i (dram_adr), .dat_i (dram_dat_w), .sel_i (dram_sel),
    .ack_o (dram_ack), .dat_o (dram_dat_r)
  );

endmodule

// File: dv/pulp_soc_properties.sv
module pulp_soc_properties (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           host_stb_i,
  input logic           host_ack_o,
  input logic           ext_cyc_o,
  input logic           ext_stb_o,
  input logic           ext_we_o,
  input soc_pkg::addr_t ext_adr_o,
  input soc_pkg::data_t ext_dat_o,
  input soc_pkg::sel_t  ext_sel_o,
  input logic           ext_ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // sampled on the falling edge, where acks and requests are both settled
  host_ack_with_stb: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    host_ack_o |-> host_stb_i)
    else $error("host ack without host stb");

  ext_stb_with_cyc: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    ext_stb_o |-> ext_cyc_o)
    else $error("ext stb without ext cyc");

  host_ack_single: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    host_ack_o |=> !host_ack_o)
    else $error("host ack held for two cycles");

  // waiting request must not move
  ext_req_stable: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    (ext_stb_o && !ext_ack_i) |=> ($stable(ext_stb_o) && $stable(ext_we_o) &&
      $stable(ext_adr_o) && $stable(ext_dat_o) && $stable(ext_sel_o)))
    else $error("ext request changed before ack");

endmodule

bind pulp_soc pulp_soc_properties pulp_soc_properties_i (.*);

// File: dv/tb_pulp_soc.sv
module tb_pulp_soc;
  timeunit 1ns;
  timeprecision 1ps;

  import soc_pkg::*;

  localparam int unsigned L2_SIZE    = 65536;
  localparam int unsigned MAX_CYCLES = 4000;
  localparam addr_t       EXT_BASE   = 32'h3000_0000;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        host_cyc_i;
  logic        host_stb_i;
  logic        host_we_i;
  addr_t       host_adr_i;
  data_t       host_dat_i;
  sel_t        host_sel_i;
  logic        host_ack_o;
  data_t       host_dat_o;
  logic        ext_cyc_o;
  logic        ext_stb_o;
  logic        ext_we_o;
  addr_t       ext_adr_o;
  data_t       ext_dat_o;
  sel_t        ext_sel_o;
  logic        ext_ack_i;
  data_t       ext_dat_i;

  logic [31:0] lfsr_q;
  data_t       shadow [addr_t];
  data_t       ext_mem [addr_t];
  data_t       exp_q [$];
  int unsigned ext_req_count;
  int unsigned ext_host_count;

  pulp_soc pulp_soc_i (.*);

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t dat, input sel_t sel);
    data_t res;
    res = old;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = dat[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected read data from the shadow copy
  function automatic data_t expected_read(input addr_t adr, input sel_t sel);
    data_t word;
    word = shadow.exists(adr >> 3) ? shadow[adr >> 3] : '0;
    if (addr_region(adr, L2_SIZE) == REGION_DBG) begin
      // narrow path only fetches the halves the selects touch
      if (!(|sel[7:4])) begin
        word[63:32] = '0;
      end
      if ((|sel[7:4]) && !(|sel[3:0])) begin
        word[31:0] = '0;
      end
    end
    return word;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // one wishbone classic transfer between falling edges
  task automatic bus_access(input logic we, input addr_t adr, input data_t dat, input sel_t sel);
    int unsigned waited;
    region_e     region;
    waited = 0;
    region = addr_region(adr, L2_SIZE);
    if (we) begin
      shadow[adr >> 3] = merge_bytes(expected_read(adr, 8'hFF), dat, sel);
    end else begin
      exp_q.push_back(expected_read(adr, sel));
    end
    if (region == REGION_EXT) begin
      ext_host_count++;
    end
    host_cyc_i <= 1'b1;
    host_stb_i <= 1'b1;
    host_we_i  <= we;
    host_adr_i <= adr;
    host_dat_i <= dat;
    host_sel_i <= sel;
    do begin
      @(negedge clk_i);
      waited++;
    end while (host_ack_o !== 1'b1);
    if (region == REGION_L2) begin
      check(waited, 1, "L2 ack latency in cycles");
    end
    host_cyc_i <= 1'b0;
    host_stb_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // pool of four words per region written in full before mixed traffic
  task automatic exercise_region(input addr_t base, input int unsigned span_words,
                                 input int unsigned n_ops);
    addr_t pool [4];
    addr_t word;
    data_t dat;
    for (int i = 0; i < 4; i++) begin
      word = addr_t'(rand_bits(16) % span_words);
      // alternate the low word bit so l2 hits both banks
      pool[i] = base + {word[28:1], i[0], 3'b000};
      dat = {rand_bits(32), rand_bits(32)};
      bus_access(1'b1, pool[i], dat, '1);
    end
    for (int n = 0; n < n_ops; n++) begin
      word = pool[rand_bits(2)];
      dat = {rand_bits(32), rand_bits(32)};
      bus_access(rand_bits(1) == 1, word, dat, sel_t'(rand_bits(8)));
    end
    for (int i = 0; i < 4; i++) begin
      bus_access(1'b0, pool[i], '0, '1);
    end
  endtask

  // compare every acknowledged read against the queued reference value
  always @(negedge clk_i) begin
    if (host_ack_o === 1'b1 && host_we_i === 1'b0) begin
      if (exp_q.size() == 0) begin
        $display("read acknowledged at %0t ns with no expected value queued", $time);
        $display("TESTS FAILED");
        $fatal(1);
      end else begin
        check(host_dat_o, exp_q.pop_front(), "host read data");
      end
    end
  end

  // external slave with 0 to 3 cycles of ack delay
  initial begin : ext_model
    int unsigned delay;
    addr_t       key;
    forever begin
      @(negedge clk_i);
      if (ext_cyc_o === 1'b1 && ext_stb_o === 1'b1) begin
        ext_req_count++;
        check(ext_adr_o, host_adr_i, "ext address");
        check(ext_dat_o, host_dat_i, "ext write data");
        check(ext_sel_o, host_sel_i, "ext byte selects");
        check(ext_we_o, host_we_i, "ext direction");
        key = ext_adr_o >> 3;
        delay = rand_bits(2);
        repeat (delay) @(negedge clk_i);
        if (ext_we_o) begin
          ext_mem[key] = merge_bytes(ext_mem.exists(key) ? ext_mem[key] : '0,
                                     ext_dat_o, ext_sel_o);
        end else begin
          ext_dat_i <= ext_mem.exists(key) ? ext_mem[key] : '0;
        end
        ext_ack_i <= 1'b1;
        @(negedge clk_i);
        ext_ack_i <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin : stimulus
    lfsr_q = 32'h96cf;
    ext_req_count = 0;
    ext_host_count = 0;
    rst_n_i = 1'b0;
    host_cyc_i = 1'b0;
    host_stb_i = 1'b0;
    host_we_i = 1'b0;
    host_adr_i = '0;
    host_dat_i = '0;
    host_sel_i = '0;
    ext_ack_i = 1'b0;
    ext_dat_i = '0;
    repeat (3) @(negedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check(host_ack_o, 1'b0, "host ack after reset");
    check(ext_cyc_o, 1'b0, "ext cyc after reset");
    check(ext_stb_o, 1'b0, "ext stb after reset");

    exercise_region(L2_BASE, L2_SIZE / 8, 60);

    // debug path full word then single halves
    bus_access(1'b1, DBG_BASE + 32'h40, 64'h0123_4567_89AB_CDEF, 8'hFF);
    bus_access(1'b0, DBG_BASE + 32'h40, '0, 8'hFF);
    bus_access(1'b0, DBG_BASE + 32'h40, '0, 8'h0F);
    bus_access(1'b0, DBG_BASE + 32'h40, '0, 8'hF0);
    bus_access(1'b1, DBG_BASE + 32'h40, 64'hFFEE_DDCC_BBAA_9988, 8'h5A);
    bus_access(1'b0, DBG_BASE + 32'h40, '0, 8'hFF);
    exercise_region(DBG_BASE, DBG_SIZE / 8, 40);

    exercise_region(EXT_BASE, 4096, 40);

    check(exp_q.size(), 0, "reads left without a response");
    check(ext_req_count, ext_host_count, "ext requests seen per host request");
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: filelist.f
common/soc_pkg.sv
soc_bus/soc_bus.sv
l2_mem/l2_mem.sv
verilog/dw_downsizer.sv
verilog/dbg_scratch_ram.sv
verilog/pulp_soc.sv
dv/pulp_soc_properties.sv
dv/tb_pulp_soc.sv

// File: Bender.yml
package:
  name: pulp_soc

sources:
  - common/soc_pkg.sv
  - soc_bus/soc_bus.sv
  - l2_mem/l2_mem.sv
  - verilog/dw_downsizer.sv
  - verilog/dbg_scratch_ram.sv
  - verilog/pulp_soc.sv
  - target: test
    files:
      - dv/pulp_soc_properties.sv
      - dv/tb_pulp_soc.sv
